//--- memc_config.svh
`ifndef MEMC_CONFIG_SVH
`define MEMC_CONFIG_SVH

// ####################
// address map
// ####################

// pm and dm addresses are both 14 bits wide.
`define MEMC_ADDR_W 14

// internal overlay pages per space.
`define MEMC_PAGES 8

// overlay register width; values 8 to 15 select no internal page.
`define MEMC_OVL_W 4

// upper nine address bits of the top 32-word dm page.
`define MEMC_MMIO_TAG 9'h1ff

// ####################
// mmio register offsets
// ####################

`define MEMC_OFS_SYSR 5'h1f
`define MEMC_OFS_WSCR 5'h1e
`define MEMC_OFS_CKR  5'h1a
`define MEMC_OFS_DCTL 5'h00
`define MEMC_OFS_DOVL 5'h19

`endif

//--- memc_pkg.sv
`include "memc_config.svh"

package memc_pkg;

  // one access command for a single memory space.
  typedef struct packed {
    logic                    read;
    logic                    write;
    logic [`MEMC_ADDR_W-1:0] addr;
  } busCmd;

  // writes that have moved on to the commit stage.
  typedef struct packed {
    logic dmWrite;
    logic pmWrite;
  } writePair;

  // selects for one memory space; writeN is active low.
  typedef struct packed {
    logic [`MEMC_PAGES-1:0] pageCs;
    logic [`MEMC_PAGES-1:0] pageOe;
    logic                   mainCs;
    logic                   mainOe;
    logic                   writeN;
  } bankStrobes;

  typedef struct packed {
    logic selSysr, selWscr, selCkr, selDctl, selDovl;
    logic weSysr, weWscr, weCkr, weDctl, weDovl;
  } mmioSel;

  // field order follows the SYSR bit layout, msb first.
  typedef struct packed {
    logic [1:0] ecmAwait;
    logic       tbEn;
    logic       sp0En;
    logic       sp1En;
    logic       biasRnd;
    logic [2:0] dwWait;
    logic [2:0] drWait;
    logic [3:0] ecmWait;
  } sysrFields;

endpackage

//--- memcStage.sv
`timescale 1ns/1ps

module memcStage #(
  parameter type payloadT = logic
) (
  input  logic    DSPCLK,
  input  logic    PPclr,
  input  logic    load,
  input  logic    clear,
  input  payloadT d,
  output payloadT q
);

  // a load wins over a clear in the same cycle.
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      q <= '0;
    end
    else if (load) begin
      q <= d;
    end
    else if (clear) begin
      q <= '0;
    end
  end

endmodule

//--- memMap.sv
`timescale 1ns/1ps

`include "memc_config.svh"

module memMap (
  input  logic                    pmBdrySel,
  input  logic [`MEMC_ADDR_W-1:0] dmAddr,
  input  logic [`MEMC_ADDR_W-1:0] pmAddr,
  output logic                    pmRegion,
  output logic                    dmRegion,
  output logic                    dmMain,
  output logic                    mmioPage
);

  localparam int topBit = `MEMC_ADDR_W - 1;
  localparam logic [`MEMC_ADDR_W-1:0] dmMainBase = `MEMC_ADDR_W'('h2000);

  // ####################
  // program memory
  // ####################

  // the boundary select moves the overlay window down to 2000 hex.
  assign pmRegion = pmBdrySel ? pmAddr[topBit] : (pmAddr[topBit -: 2] == 2'b11);

  // ####################
  // data memory
  // ####################

  assign dmRegion = (dmAddr < dmMainBase); // overlay window below the main block.

  assign mmioPage = (dmAddr[topBit -: 9] == `MEMC_MMIO_TAG);

  // the register page sits at the very top of the main block.
  assign dmMain = (dmAddr >= dmMainBase) && !mmioPage;

endmodule

//--- memBankDecode.sv
`timescale 1ns/1ps

`include "memc_config.svh"

module memBankDecode (
  input  logic                   DSPCLK,
  input  logic                   PPclr,
  input  logic                   region,
  input  logic                   mainHit,
  input  logic [`MEMC_OVL_W-1:0] ovl,
  input  logic                   readE,
  input  logic                   writeC,
  input  logic                   goCx,
  output memc_pkg::bankStrobes   strobes
);

  logic [`MEMC_PAGES-1:0] pageHit;
  logic [`MEMC_PAGES-1:0] pageOeQ;
  logic                   mainOeQ;
  logic                   csEn;
  logic                   anyHit;

  // ####################
  // page decode
  // ####################

  // overlay values past the last page match nothing.
  for (genvar i = 0; i < `MEMC_PAGES; i++) begin : gPage
    assign pageHit[i] = region && (ovl == `MEMC_OVL_W'(i));
  end

  assign anyHit = (|pageHit) || mainHit;
  assign csEn   = readE || writeC;

  // output enables trail the read select by one cycle.
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      pageOeQ <= '0;
      mainOeQ <= 1'b0;
    end
    else begin
      pageOeQ <= pageHit & {`MEMC_PAGES{readE}};
      mainOeQ <= mainHit && readE;
    end
  end

  // ####################
  // strobe outputs
  // ####################

  assign strobes = '{
    pageCs: pageHit & {`MEMC_PAGES{csEn}},
    pageOe: pageOeQ,
    mainCs: mainHit && csEn,
    mainOe: mainOeQ,
    writeN: !(writeC && goCx && anyHit) // low only while the write commits.
  };

endmodule

//--- mmioDecode.sv
`timescale 1ns/1ps

`include "memc_config.svh"

module mmioDecode (
  input  logic                DSPCLK,
  input  logic                PPclr,
  input  logic                mmioPage,
  input  logic [4:0]          offset,
  input  logic                readE,
  input  logic                writeE,
  input  logic                goCx,
  input  logic [15:0]         dmd,
  output memc_pkg::mmioSel    sel,
  output memc_pkg::sysrFields sysr
);

  import memc_pkg::*;

  logic selEn;
  logic weEn;
  logic hitSysr, hitWscr, hitCkr, hitDctl, hitDovl;

  // ####################
  // register decode
  // ####################

  assign selEn = mmioPage && (readE || writeE);
  assign weEn  = mmioPage && writeE && goCx; // write enables fire with the commit.

  assign hitSysr = (offset == `MEMC_OFS_SYSR);
  assign hitWscr = (offset == `MEMC_OFS_WSCR);
  assign hitCkr  = (offset == `MEMC_OFS_CKR);
  assign hitDctl = (offset == `MEMC_OFS_DCTL);
  assign hitDovl = (offset == `MEMC_OFS_DOVL);

  assign sel.selSysr = selEn && hitSysr;
  assign sel.selWscr = selEn && hitWscr;
  assign sel.selCkr  = selEn && hitCkr;
  assign sel.selDctl = selEn && hitDctl;
  assign sel.selDovl = selEn && hitDovl;

  assign sel.weSysr = weEn && hitSysr;
  assign sel.weWscr = weEn && hitWscr;
  assign sel.weCkr  = weEn && hitCkr;
  assign sel.weDctl = weEn && hitDctl;
  assign sel.weDovl = weEn && hitDovl;

  // ####################
  // system register
  // ####################

  // the data bus carries the new value in the commit cycle.
  always_ff @(posedge DSPCLK or posedge PPclr) begin
    if (PPclr) begin
      sysr <= '0;
    end
    else if (sel.weSysr) begin
      sysr <= sysrFields'(dmd);
    end
  end

endmodule

//--- memcTop.sv
`timescale 1ns/1ps

`include "memc_config.svh"

module memcTop (
  input  logic                    DSPCLK,
  input  logic                    PPclr,
  input  logic                    dmReadR,
  input  logic                    dmWriteR,
  input  logic                    pmReadR,
  input  logic                    pmWriteR,
  input  logic                    dummyR,
  input  logic [`MEMC_ADDR_W-1:0] dmAddrR,
  input  logic [`MEMC_ADDR_W-1:0] pmAddrR,
  input  logic                    goEx,
  input  logic                    goCx,
  input  logic                    idle,
  input  logic                    pmBdrySel,
  input  logic [`MEMC_OVL_W-1:0]  dmOvl,
  input  logic [`MEMC_OVL_W-1:0]  pmOvl,
  input  logic [15:0]             dmd,
  output memc_pkg::bankStrobes    dmStrobes,
  output memc_pkg::bankStrobes    pmStrobes,
  output memc_pkg::mmioSel        regSel,
  output memc_pkg::sysrFields     sysr
);

  import memc_pkg::*;

  busCmd    dmCmdR, pmCmdR;
  busCmd    dmCmdE, pmCmdE;
  writePair wrE, wrC;
  logic     pmRegion, dmRegion, dmMain, mmioPage;

  // ####################
  // pipeline stages
  // ####################

  // dummy cycles never reach the execute stage as real accesses.
  assign dmCmdR = '{read: dmReadR && !dummyR, write: dmWriteR && !dummyR, addr: dmAddrR};
  assign pmCmdR = '{read: pmReadR && !dummyR, write: pmWriteR && !dummyR, addr: pmAddrR};
  assign wrE    = '{dmWrite: dmCmdE.write, pmWrite: pmCmdE.write};

  memcStage #(.payloadT(busCmd)) uDmStage (
    .DSPCLK(DSPCLK), .PPclr(PPclr), .load(goEx), .clear(1'b0), .d(dmCmdR), .q(dmCmdE)
  );

  memcStage #(.payloadT(busCmd)) uPmStage (
    .DSPCLK(DSPCLK), .PPclr(PPclr), .load(goEx), .clear(1'b0), .d(pmCmdR), .q(pmCmdE)
  );

  // an idle core drops any write still waiting to commit.
  memcStage #(.payloadT(writePair)) uWrStage (
    .DSPCLK(DSPCLK), .PPclr(PPclr), .load(goCx), .clear(idle), .d(wrE), .q(wrC)
  );

  // ####################
  // decoders
  // ####################

  memMap uMap (
    .pmBdrySel(pmBdrySel), .dmAddr(dmCmdE.addr), .pmAddr(pmCmdE.addr),
    .pmRegion(pmRegion), .dmRegion(dmRegion), .dmMain(dmMain), .mmioPage(mmioPage)
  );

  memBankDecode uDmBank (
    .DSPCLK(DSPCLK), .PPclr(PPclr), .region(dmRegion), .mainHit(dmMain), .ovl(dmOvl),
    .readE(dmCmdE.read), .writeC(wrC.dmWrite), .goCx(goCx), .strobes(dmStrobes)
  );

  // program memory has no main block.
  memBankDecode uPmBank (
    .DSPCLK(DSPCLK), .PPclr(PPclr), .region(pmRegion), .mainHit(1'b0), .ovl(pmOvl),
    .readE(pmCmdE.read), .writeC(wrC.pmWrite), .goCx(goCx), .strobes(pmStrobes)
  );

  mmioDecode uMmio (
    .DSPCLK(DSPCLK), .PPclr(PPclr), .mmioPage(mmioPage), .offset(dmCmdE.addr[4:0]),
    .readE(dmCmdE.read), .writeE(dmCmdE.write), .goCx(goCx), .dmd(dmd),
    .sel(regSel), .sysr(sysr)
  );

endmodule

//--- memc_chk.sv
`timescale 1ns/1ps

module memcChk (
  input logic                 DSPCLK,
  input logic                 PPclr,
  input logic                 goCx,
  input memc_pkg::bankStrobes strobes
);

  // ####################
  // strobe rules
  // ####################

  pageOeAfterCs: assert property (
    @(posedge DSPCLK) disable iff (PPclr)
      (strobes.pageOe & ~$past(strobes.pageCs)) == '0
  ) else $error("page output enable without a page chip select one cycle before");

  mainOeAfterCs: assert property (
    @(posedge DSPCLK) disable iff (PPclr)
      strobes.mainOe |-> $past(strobes.mainCs)
  ) else $error("main output enable without a main chip select one cycle before");

  // the write strobe belongs to the commit cycle only.
  writeOnlyInCommit: assert property (
    @(posedge DSPCLK) disable iff (PPclr)
      !strobes.writeN |-> goCx
  ) else $error("write strobe low outside a goCx cycle");

endmodule

bind memBankDecode memcChk uChk (
  .DSPCLK(DSPCLK), .PPclr(PPclr), .goCx(goCx), .strobes(strobes)
);

//--- tb_memc.sv
`timescale 1ns/1ps

`include "memc_config.svh"

module tb_memc;

  import memc_pkg::*;

  localparam int maxWait = 8;

  logic                    DSPCLK;
  logic                    PPclr;
  logic                    dmReadR, dmWriteR, pmReadR, pmWriteR, dummyR;
  logic [`MEMC_ADDR_W-1:0] dmAddrR, pmAddrR;
  logic                    goEx, goCx, idle, pmBdrySel;
  logic [`MEMC_OVL_W-1:0]  dmOvl, pmOvl;
  logic [15:0]             dmd;
  bankStrobes              dmStrobes, pmStrobes;
  mmioSel                  regSel;
  sysrFields               sysr;

  integer seed = 32'h704c_a9ff;
  int checkCount = 0;
  int errorCount = 0;
  logic [4:0] ofsList [5] = '{`MEMC_OFS_SYSR, `MEMC_OFS_WSCR, `MEMC_OFS_CKR,
                              `MEMC_OFS_DCTL, `MEMC_OFS_DOVL};

  memcTop dut (.*);

  initial begin
    DSPCLK = 1'b0;
    forever #5 DSPCLK = ~DSPCLK;
  end

  // ####################
  // helpers
  // ####################

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic endTest(input string name, input int errStart);
    $display("test %s finished with %0d errors", name, errorCount - errStart);
  endtask

  task automatic nextCycle;
    @(posedge DSPCLK);
    #1;
  endtask

  task automatic clearCmd;
    dmReadR = 1'b0;
    dmWriteR = 1'b0;
    pmReadR = 1'b0;
    pmWriteR = 1'b0;
    goEx = 1'b0;
  endtask

  task automatic driveCmd(input logic dmRd, input logic dmWr, input logic pmRd,
                          input logic [`MEMC_ADDR_W-1:0] dmA,
                          input logic [`MEMC_ADDR_W-1:0] pmA);
    nextCycle();
    dmReadR = dmRd;
    dmWriteR = dmWr;
    pmReadR = pmRd;
    dmAddrR = dmA;
    pmAddrR = pmA;
    goEx = 1'b1;
    nextCycle();
    clearCmd(); // the command now sits in the execute stage.
  endtask

  // two idle cycles empty both stages and let the output enables drop.
  task automatic flushPipe;
    nextCycle();
    clearCmd();
    dummyR = 1'b0;
    goEx = 1'b1;
    goCx = 1'b0;
    idle = 1'b1;
    nextCycle();
    goEx = 1'b0;
    nextCycle();
    idle = 1'b0;
  endtask

  task automatic waitDmOe(output int cycles);
    cycles = 0;
    while (dmStrobes.pageOe == '0 && !dmStrobes.mainOe && cycles < maxWait) begin
      @(negedge DSPCLK);
      cycles++;
    end
    assert (dmStrobes.pageOe != '0 || dmStrobes.mainOe) else begin
      $display("Error at %0t ns: no dm output enable within %0d cycles", $time, maxWait);
      errorCount++;
    end
  endtask

  function automatic mmioSel expectedSel(input int k, input bit withWe);
    mmioSel s;
    s = '0;
    case (k)
      0: {s.selSysr, s.weSysr} = {1'b1, withWe};
      1: {s.selWscr, s.weWscr} = {1'b1, withWe};
      2: {s.selCkr, s.weCkr} = {1'b1, withWe};
      3: {s.selDctl, s.weDctl} = {1'b1, withWe};
      default: {s.selDovl, s.weDovl} = {1'b1, withWe};
    endcase
    return s;
  endfunction

  // ####################
  // tests
  // ####################

  task automatic testReset;
    int errStart;
    bankStrobes idleStrobes;
    errStart = errorCount;
    idleStrobes = '0;
    idleStrobes.writeN = 1'b1;
    @(negedge DSPCLK);
    checkVal("dmStrobes", dmStrobes, idleStrobes);
    checkVal("pmStrobes", pmStrobes, idleStrobes);
    checkVal("regSel", regSel, '0);
    checkVal("sysr", sysr, '0);
    endTest("reset", errStart);
  endtask

  task automatic testDmPageRead;
    int errStart;
    int cycles;
    logic [7:0] expMask;
    errStart = errorCount;
    for (int n = 0; n < 8; n++) begin
      flushPipe();
      dmOvl = 4'(n);
      driveCmd(1'b1, 1'b0, 1'b0, 14'h0100 + 14'(n), '0);
      @(negedge DSPCLK);
      expMask = 8'(1 << n);
      checkVal("dmStrobes.pageCs", dmStrobes.pageCs, expMask);
      checkVal("dmStrobes.mainCs", dmStrobes.mainCs, 1'b0);
      checkVal("dmStrobes.pageOe", dmStrobes.pageOe, '0);
      waitDmOe(cycles);
      checkVal("cs to oe cycles", cycles, 1);
      checkVal("dmStrobes.pageOe", dmStrobes.pageOe, expMask);
    end
    flushPipe();
    dmOvl = 4'd9; // external overlay, no internal page.
    driveCmd(1'b1, 1'b0, 1'b0, 14'h0100, '0);
    @(negedge DSPCLK);
    checkVal("dmStrobes.pageCs", dmStrobes.pageCs, '0);
    @(negedge DSPCLK);
    checkVal("dmStrobes.pageOe", dmStrobes.pageOe, '0);
    endTest("dmPageRead", errStart);
  endtask

  task automatic testMainMmio;
    int errStart;
    int cycles;
    errStart = errorCount;
    flushPipe();
    driveCmd(1'b1, 1'b0, 1'b0, 14'h2100, '0);
    @(negedge DSPCLK);
    checkVal("dmStrobes.mainCs", dmStrobes.mainCs, 1'b1);
    checkVal("dmStrobes.pageCs", dmStrobes.pageCs, '0);
    checkVal("regSel", regSel, '0);
    waitDmOe(cycles);
    checkVal("cs to oe cycles", cycles, 1);
    checkVal("dmStrobes.mainOe", dmStrobes.mainOe, 1'b1);
    for (int k = 0; k < 5; k++) begin
      flushPipe();
      driveCmd(1'b1, 1'b0, 1'b0, {`MEMC_MMIO_TAG, ofsList[k]}, '0);
      @(negedge DSPCLK);
      checkVal("dmStrobes.pageCs", dmStrobes.pageCs, '0);
      checkVal("dmStrobes.mainCs", dmStrobes.mainCs, 1'b0);
      checkVal("regSel", regSel, expectedSel(k, 1'b0));
    end
    endTest("mainMmio", errStart);
  endtask

  task automatic testWriteCommit;
    int errStart;
    errStart = errorCount;
    flushPipe();
    dmOvl = 4'd3;
    driveCmd(1'b0, 1'b1, 1'b0, 14'h0123, '0);
    goCx = 1'b1; // this cycle moves the write into the commit stage.
    @(negedge DSPCLK);
    checkVal("dmStrobes.writeN", dmStrobes.writeN, 1'b1);
    nextCycle();
    @(negedge DSPCLK);
    checkVal("dmStrobes.writeN", dmStrobes.writeN, 1'b0);
    checkVal("dmStrobes.pageCs", dmStrobes.pageCs, 8'h08);
    nextCycle();
    goCx = 1'b0;
    @(negedge DSPCLK);
    checkVal("dmStrobes.writeN", dmStrobes.writeN, 1'b1);
    flushPipe();
    dummyR = 1'b1;
    driveCmd(1'b0, 1'b1, 1'b0, 14'h0123, '0);
    dummyR = 1'b0;
    goCx = 1'b1;
    for (int c = 0; c < 2; c++) begin
      @(negedge DSPCLK);
      checkVal("dmStrobes.writeN", dmStrobes.writeN, 1'b1);
      checkVal("dmStrobes.pageCs", dmStrobes.pageCs, '0);
      nextCycle();
    end
    goCx = 1'b0;
    endTest("writeCommit", errStart);
  endtask

  task automatic testSysrWrite;
    int errStart;
    logic [31:0] rnd;
    logic [15:0] val;
    errStart = errorCount;
    rnd = $random(seed);
    val = rnd[15:0];
    flushPipe();
    dmd = val;
    driveCmd(1'b0, 1'b1, 1'b0, {`MEMC_MMIO_TAG, `MEMC_OFS_SYSR}, '0);
    goCx = 1'b1;
    @(negedge DSPCLK);
    checkVal("regSel", regSel, expectedSel(0, 1'b1));
    nextCycle();
    goCx = 1'b0;
    @(negedge DSPCLK);
    checkVal("regSel.weSysr", regSel.weSysr, 1'b0);
    checkVal("sysr.ecmAwait", sysr.ecmAwait, val[15:14]);
    checkVal("sysr.tbEn", sysr.tbEn, val[13]);
    checkVal("sysr.sp0En", sysr.sp0En, val[12]);
    checkVal("sysr.sp1En", sysr.sp1En, val[11]);
    checkVal("sysr.biasRnd", sysr.biasRnd, val[10]);
    checkVal("sysr.dwWait", sysr.dwWait, val[9:7]);
    checkVal("sysr.drWait", sysr.drWait, val[6:4]);
    checkVal("sysr.ecmWait", sysr.ecmWait, val[3:0]);
    endTest("sysrWrite", errStart);
  endtask

  task automatic testPmBoundary;
    int errStart;
    errStart = errorCount;
    flushPipe();
    pmOvl = 4'd5;
    pmBdrySel = 1'b1;
    driveCmd(1'b0, 1'b0, 1'b1, '0, 14'h2000);
    @(negedge DSPCLK);
    checkVal("pmStrobes.pageCs", pmStrobes.pageCs, 8'h20);
    flushPipe();
    pmBdrySel = 1'b0;
    driveCmd(1'b0, 1'b0, 1'b1, '0, 14'h2000);
    @(negedge DSPCLK);
    checkVal("pmStrobes.pageCs", pmStrobes.pageCs, '0);
    flushPipe();
    driveCmd(1'b0, 1'b0, 1'b1, '0, 14'h3000);
    @(negedge DSPCLK);
    checkVal("pmStrobes.pageCs", pmStrobes.pageCs, 8'h20);
    endTest("pmBoundary", errStart);
  endtask

  // ####################
  // main sequence
  // ####################

  initial begin
    clearCmd();
    dummyR = 1'b0;
    dmAddrR = '0;
    pmAddrR = '0;
    goCx = 1'b0;
    idle = 1'b0;
    pmBdrySel = 1'b0;
    dmOvl = '0;
    pmOvl = '0;
    dmd = '0;
    PPclr = 1'b1;
    repeat (3) @(posedge DSPCLK);
    #1;
    PPclr = 1'b0;
    testReset();
    testDmPageRead();
    testMainMmio();
    testWriteCommit();
    testSysrWrite();
    testPmBoundary();
    $display("summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end
    else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
memc_pkg.sv
memcStage.sv
memMap.sv
memBankDecode.sv
mmioDecode.sv
memcTop.sv
memc_chk.sv
tb_memc.sv
